//--- Bender.yml
package:
  name: accel_reader

sources:
  - src/accel_pkg.sv
  - src/scl_timer.sv
  - src/i2c_burst_engine.sv
  - src/axis_assembler.sv
  - src/accel_regs.sv
  - src/accel_reader_top.sv
  - target: test
    files:
      - verif/adxl345_model.sv
      - verif/tb_accel_reader.sv

//--- accel_reader.f
src/accel_pkg.sv
src/scl_timer.sv
src/i2c_burst_engine.sv
src/axis_assembler.sv
src/accel_regs.sv
src/accel_reader_top.sv
verif/adxl345_model.sv
verif/tb_accel_reader.sv

//--- src/accel_pkg.sv
package accel_pkg;

   ////////////////////////////////////////
   // Widths that carry a meaning
   ////////////////////////////////////////

   typedef logic [7:0]         byte_t;       // One byte on the I2C bus
   typedef logic signed [15:0] axis_t;       // One acceleration sample
   typedef logic [6:0]         dev_addr_t;   // 7-bit I2C device address
   typedef logic [2:0]         wb_adr_t;     // Wishbone register index
   typedef logic [15:0]        wb_dat_t;
   typedef logic [2:0]         byte_idx_t;   // Byte position within a burst

   // X low, X high, Y low, Y high, Z low, Z high
   localparam int BURST_BYTES = 6;

   ////////////////////////////////////////
   // Register map
   ////////////////////////////////////////

   localparam wb_adr_t REG_CTRL     = 3'd0;
   localparam wb_adr_t REG_STATUS   = 3'd1;
   localparam wb_adr_t REG_DEV_ADDR = 3'd2;
   localparam wb_adr_t REG_PTR      = 3'd3;
   localparam wb_adr_t REG_X        = 3'd4;
   localparam wb_adr_t REG_Y        = 3'd5;
   localparam wb_adr_t REG_Z        = 3'd6;

   localparam dev_addr_t DEV_ADDR_RESET = 7'h53;   // ADXL345 with ALT ADDRESS tied low
   localparam byte_t     PTR_RESET      = 8'h32;   // DATAX0

   // Phases of the burst engine
   typedef enum logic [2:0] {
      PHASE_IDLE,
      PHASE_START,
      PHASE_ADDRESS,
      PHASE_POINTER,
      PHASE_ACK,
      PHASE_RSTART,
      PHASE_READ,
      PHASE_STOP
   } bus_phase_e;

endpackage

//--- src/accel_reader_top.sv
`timescale 1ns/100ps

module accel_reader_top #(
   parameter int unsigned SCL_HALF_CYCLES = 4   // System clocks per SCL half period
) (
   input  logic               Clk_i,
   input  logic               Reset_i,
   input  logic               wb_cyc_i,
   input  logic               wb_stb_i,
   input  logic               wb_we_i,
   input  accel_pkg::wb_adr_t wb_adr_i,
   input  accel_pkg::wb_dat_t wb_dat_i,
   output accel_pkg::wb_dat_t wb_dat_o,
   output logic               wb_ack_o,
   output logic               scl_o,
   input  logic               sda_i,
   output logic               sda_oe_o,
   output logic               irq_o
);

   logic                 start;
   logic                 busy;
   logic                 done;
   logic                 nack;
   accel_pkg::dev_addr_t dev_addr;
   accel_pkg::byte_t     ptr;
   logic                 scl_run;
   logic                 scl_rise;
   logic                 scl_fall;
   accel_pkg::byte_t     rx_byte;
   logic                 byte_valid;
   accel_pkg::byte_idx_t byte_idx;
   accel_pkg::axis_t     axis_x;
   accel_pkg::axis_t     axis_y;
   accel_pkg::axis_t     axis_z;

   accel_regs u_regs (
      .Clk_i, .Reset_i,
      .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
      .start_o (start), .dev_addr_o (dev_addr), .ptr_o (ptr),
      .busy_i (busy), .done_i (done), .nack_i (nack),
      .axis_x_i (axis_x), .axis_y_i (axis_y), .axis_z_i (axis_z),
      .irq_o
   );

   i2c_burst_engine u_engine (
      .Clk_i, .Reset_i,
      .start_i (start), .dev_addr_i (dev_addr), .ptr_i (ptr),
      .scl_rise_i (scl_rise), .scl_fall_i (scl_fall), .sda_i,
      .scl_run_o (scl_run), .sda_oe_o,
      .rx_byte_o (rx_byte), .byte_valid_o (byte_valid), .byte_idx_o (byte_idx),
      .busy_o (busy), .done_o (done), .nack_o (nack)
   );

   scl_timer #(.SCL_HALF_CYCLES(SCL_HALF_CYCLES)) u_scl (
      .Clk_i, .Reset_i,
      .scl_run_i (scl_run), .scl_o, .scl_rise_o (scl_rise), .scl_fall_o (scl_fall)
   );

   axis_assembler u_axes (
      .Clk_i, .Reset_i,
      .byte_valid_i (byte_valid), .byte_idx_i (byte_idx), .rx_byte_i (rx_byte),
      .axis_x_o (axis_x), .axis_y_o (axis_y), .axis_z_o (axis_z)
   );

endmodule

//--- src/accel_regs.sv
`timescale 1ns/100ps

module accel_regs (
   input  logic                 Clk_i,
   input  logic                 Reset_i,
   input  logic                 wb_cyc_i,
   input  logic                 wb_stb_i,
   input  logic                 wb_we_i,
   input  accel_pkg::wb_adr_t   wb_adr_i,
   input  accel_pkg::wb_dat_t   wb_dat_i,
   output accel_pkg::wb_dat_t   wb_dat_o,
   output logic                 wb_ack_o,
   output logic                 start_o,
   output accel_pkg::dev_addr_t dev_addr_o,
   output accel_pkg::byte_t     ptr_o,
   input  logic                 busy_i,
   input  logic                 done_i,
   input  logic                 nack_i,
   input  accel_pkg::axis_t     axis_x_i,
   input  accel_pkg::axis_t     axis_y_i,
   input  accel_pkg::axis_t     axis_z_i,
   output logic                 irq_o
);

   logic               req;
   logic               wr_req;
   logic               rd_req;
   logic               done_q;   // Sticky until STATUS is read
   logic               nack_q;
   accel_pkg::wb_dat_t rd_data;

   assign req    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
   assign wr_req = req & wb_we_i;
   assign rd_req = req & ~wb_we_i;

   always_comb
   begin
      unique case (wb_adr_i)
         accel_pkg::REG_STATUS:   rd_data = {13'd0, nack_q, done_q, busy_i};
         accel_pkg::REG_DEV_ADDR: rd_data = accel_pkg::wb_dat_t'(dev_addr_o);
         accel_pkg::REG_PTR:      rd_data = accel_pkg::wb_dat_t'(ptr_o);
         accel_pkg::REG_X:        rd_data = axis_x_i;
         accel_pkg::REG_Y:        rd_data = axis_y_i;
         accel_pkg::REG_Z:        rd_data = axis_z_i;
         default:                 rd_data = '0;   // CTRL only triggers
      endcase
   end

   ////////////////////////////////////////
   // Bus side
   ////////////////////////////////////////

   always_ff @(posedge Clk_i or negedge Reset_i)
   begin
      if (!Reset_i)
      begin
         wb_ack_o   <= 1'b0;
         wb_dat_o   <= '0;
         start_o    <= 1'b0;
         dev_addr_o <= accel_pkg::DEV_ADDR_RESET;
         ptr_o      <= accel_pkg::PTR_RESET;
      end
      else
      begin
         wb_ack_o <= req;
         start_o  <= wr_req && wb_adr_i == accel_pkg::REG_CTRL && wb_dat_i[0];
         if (rd_req)
            wb_dat_o <= rd_data;
         if (wr_req && wb_adr_i == accel_pkg::REG_DEV_ADDR)
            dev_addr_o <= wb_dat_i[6:0];
         if (wr_req && wb_adr_i == accel_pkg::REG_PTR)
            ptr_o <= wb_dat_i[7:0];
      end
   end

   // A completing burst wins over a clearing STATUS read
   always_ff @(posedge Clk_i or negedge Reset_i)
   begin
      if (!Reset_i)
      begin
         done_q <= 1'b0;
         nack_q <= 1'b0;
      end
      else
      begin
         if (done_i)
            done_q <= 1'b1;
         else if (rd_req && wb_adr_i == accel_pkg::REG_STATUS)
            done_q <= 1'b0;
         if (done_i && nack_i)
            nack_q <= 1'b1;
         else if (start_o)
            nack_q <= 1'b0;
      end
   end

   assign irq_o = done_q;

   ack_needs_request: assert property (@(posedge Clk_i) disable iff (!Reset_i)
      $rose(wb_ack_o) |-> wb_cyc_i && wb_stb_i);

endmodule

//--- src/axis_assembler.sv
`timescale 1ns/100ps

module axis_assembler (
   input  logic                 Clk_i,
   input  logic                 Reset_i,
   input  logic                 byte_valid_i,
   input  accel_pkg::byte_idx_t byte_idx_i,
   input  accel_pkg::byte_t     rx_byte_i,
   output accel_pkg::axis_t     axis_x_o,
   output accel_pkg::axis_t     axis_y_o,
   output accel_pkg::axis_t     axis_z_o
);

   accel_pkg::axis_t axis_q [3];
   logic [1:0]       axis_sel;
   logic             high_half;

   // Two bytes per axis, the even one is the low byte
   assign axis_sel  = byte_idx_i[2:1];
   assign high_half = byte_idx_i[0];

   always_ff @(posedge Clk_i or negedge Reset_i)
   begin
      if (!Reset_i)
      begin
         for (int i = 0; i < 3; i++)
         begin
            axis_q[i] <= '0;
         end
      end
      else if (byte_valid_i && axis_sel != 2'd3)
      begin
         if (high_half)
            axis_q[axis_sel][15:8] <= rx_byte_i;
         else
            axis_q[axis_sel][7:0]  <= rx_byte_i;
      end
   end

   assign axis_x_o = axis_q[0];
   assign axis_y_o = axis_q[1];
   assign axis_z_o = axis_q[2];

endmodule

//--- src/i2c_burst_engine.sv
`timescale 1ns/100ps

module i2c_burst_engine (
   input  logic                 Clk_i,
   input  logic                 Reset_i,
   input  logic                 start_i,
   input  accel_pkg::dev_addr_t dev_addr_i,
   input  accel_pkg::byte_t     ptr_i,
   input  logic                 scl_rise_i,
   input  logic                 scl_fall_i,
   input  logic                 sda_i,
   output logic                 scl_run_o,
   output logic                 sda_oe_o,
   output accel_pkg::byte_t     rx_byte_o,
   output logic                 byte_valid_o,
   output accel_pkg::byte_idx_t byte_idx_o,
   output logic                 busy_o,
   output logic                 done_o,
   output logic                 nack_o
);

   localparam accel_pkg::byte_idx_t LAST_BYTE = accel_pkg::byte_idx_t'(accel_pkg::BURST_BYTES - 1);

   accel_pkg::bus_phase_e phase;
   accel_pkg::bus_phase_e after_ack;   // Where to go once the ACK bit is over
   accel_pkg::dev_addr_t  addr_q;
   accel_pkg::byte_t      ptr_q;
   accel_pkg::byte_t      shift_q;
   accel_pkg::byte_idx_t  byte_cnt;
   logic [2:0]            bit_cnt;
   logic                  rd_mode;
   logic                  check_ack;   // Slave owns the ACK bit
   logic                  ack_bad;

   ////////////////////////////////////////
   // Burst FSM
   ////////////////////////////////////////

   // SDA moves on a falling strobe, except for START, Sr and STOP which move while SCL is high
   always_ff @(posedge Clk_i or negedge Reset_i)
   begin
      if (!Reset_i)
      begin
         phase        <= accel_pkg::PHASE_IDLE;
         after_ack    <= accel_pkg::PHASE_IDLE;
         addr_q       <= accel_pkg::DEV_ADDR_RESET;
         ptr_q        <= accel_pkg::PTR_RESET;
         shift_q      <= '0;
         byte_cnt     <= '0;
         bit_cnt      <= '0;
         rd_mode      <= 1'b0;
         check_ack    <= 1'b0;
         ack_bad      <= 1'b0;
         scl_run_o    <= 1'b0;
         sda_oe_o     <= 1'b0;
         byte_valid_o <= 1'b0;
         done_o       <= 1'b0;
         nack_o       <= 1'b0;
      end
      else
      begin
         done_o       <= 1'b0;
         byte_valid_o <= 1'b0;
         unique case (phase)
            accel_pkg::PHASE_IDLE:
            begin
               if (start_i)   // START: SDA falls while SCL rests high
               begin
                  addr_q    <= dev_addr_i;
                  ptr_q     <= ptr_i;
                  shift_q   <= {dev_addr_i, 1'b0};
                  rd_mode   <= 1'b0;
                  bit_cnt   <= '0;
                  byte_cnt  <= '0;
                  nack_o    <= 1'b0;
                  sda_oe_o  <= 1'b1;
                  scl_run_o <= 1'b1;
                  phase     <= accel_pkg::PHASE_START;
               end
            end
            accel_pkg::PHASE_START:
            begin
               if (scl_fall_i)
               begin
                  sda_oe_o <= ~shift_q[7];
                  bit_cnt  <= '0;
                  phase    <= accel_pkg::PHASE_ADDRESS;
               end
            end
            accel_pkg::PHASE_ADDRESS, accel_pkg::PHASE_POINTER:
            begin
               if (scl_fall_i && bit_cnt == 3'd7)
               begin
                  sda_oe_o  <= 1'b0;   // Let the slave answer
                  check_ack <= 1'b1;
                  phase     <= accel_pkg::PHASE_ACK;
                  if (phase == accel_pkg::PHASE_POINTER)
                     after_ack <= accel_pkg::PHASE_RSTART;
                  else if (rd_mode)
                     after_ack <= accel_pkg::PHASE_READ;
                  else
                     after_ack <= accel_pkg::PHASE_POINTER;
               end
               else if (scl_fall_i)
               begin
                  shift_q  <= {shift_q[6:0], 1'b0};
                  sda_oe_o <= ~shift_q[6];
                  bit_cnt  <= bit_cnt + 1'b1;
               end
            end
            accel_pkg::PHASE_ACK:
            begin
               if (scl_rise_i)
                  ack_bad <= check_ack & sda_i;
               if (scl_fall_i && ack_bad)
               begin
                  nack_o   <= 1'b1;
                  sda_oe_o <= 1'b1;   // Hold SDA low for the early STOP
                  phase    <= accel_pkg::PHASE_STOP;
               end
               else if (scl_fall_i)
               begin
                  phase   <= after_ack;
                  bit_cnt <= '0;
                  unique case (after_ack)
                     accel_pkg::PHASE_POINTER:
                     begin
                        shift_q  <= ptr_q;
                        sda_oe_o <= ~ptr_q[7];
                     end
                     accel_pkg::PHASE_STOP: sda_oe_o <= 1'b1;
                     default:               sda_oe_o <= 1'b0;
                  endcase
               end
            end
            accel_pkg::PHASE_RSTART:
            begin
               if (scl_rise_i)
               begin
                  sda_oe_o <= 1'b1;
                  shift_q  <= {addr_q, 1'b1};
                  rd_mode  <= 1'b1;
                  phase    <= accel_pkg::PHASE_START;
               end
            end
            accel_pkg::PHASE_READ:
            begin
               if (scl_rise_i)
               begin
                  shift_q <= {shift_q[6:0], sda_i};   // MSB first
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7)
                     byte_valid_o <= 1'b1;
               end
               else if (scl_fall_i && bit_cnt == 3'd0)
               begin
                  check_ack <= 1'b0;
                  sda_oe_o  <= (byte_cnt != LAST_BYTE);   // NACK the last byte
                  after_ack <= (byte_cnt == LAST_BYTE) ? accel_pkg::PHASE_STOP
                                                       : accel_pkg::PHASE_READ;
                  byte_cnt  <= byte_cnt + 1'b1;
                  phase     <= accel_pkg::PHASE_ACK;
               end
            end
            accel_pkg::PHASE_STOP:
            begin
               if (!scl_run_o)   // SCL parked high, now release SDA
               begin
                  sda_oe_o <= 1'b0;
                  done_o   <= 1'b1;
                  phase    <= accel_pkg::PHASE_IDLE;
               end
               else if (scl_rise_i)
                  scl_run_o <= 1'b0;
            end
         endcase
      end
   end

   assign rx_byte_o  = shift_q;
   assign byte_idx_o = byte_cnt;
   assign busy_o     = (phase != accel_pkg::PHASE_IDLE);

   byte_idx_in_range: assert property (@(posedge Clk_i) disable iff (!Reset_i)
      byte_valid_o |-> byte_idx_o < accel_pkg::BURST_BYTES);

endmodule

//--- src/scl_timer.sv
`timescale 1ns/100ps

module scl_timer #(
   parameter int unsigned SCL_HALF_CYCLES = 4
) (
   input  logic Clk_i,
   input  logic Reset_i,
   input  logic scl_run_i,
   output logic scl_o,
   output logic scl_rise_o,
   output logic scl_fall_o
);

   localparam int CNT_W = $clog2(SCL_HALF_CYCLES + 1);

   logic [CNT_W-1:0] half_cnt;
   logic             scl_q;
   logic             scl_d;   // SCL one clock later

   // Divider, SCL parks high whenever the engine stops it
   always_ff @(posedge Clk_i or negedge Reset_i)
   begin
      if (!Reset_i)
      begin
         half_cnt <= '0;
         scl_q    <= 1'b1;
      end
      else if (!scl_run_i)
      begin
         half_cnt <= '0;
         scl_q    <= 1'b1;
      end
      else if (half_cnt == CNT_W'(SCL_HALF_CYCLES - 1))
      begin
         half_cnt <= '0;
         scl_q    <= ~scl_q;
      end
      else
      begin
         half_cnt <= half_cnt + 1'b1;
      end
   end

   always_ff @(posedge Clk_i or negedge Reset_i)
   begin
      if (!Reset_i)
         scl_d <= 1'b1;
      else
         scl_d <= scl_q;
   end

   assign scl_o      = scl_q;
   assign scl_rise_o = scl_q & ~scl_d;   // High in the clock after the toggle
   assign scl_fall_o = ~scl_q & scl_d;

   strobes_exclusive: assert property (@(posedge Clk_i) disable iff (!Reset_i)
      !(scl_rise_o && scl_fall_o));

endmodule

//--- verif/adxl345_model.sv
`timescale 1ns/100ps

module adxl345_model (
   input  logic       scl_i,
   input  logic       sda_oe_i,     // Master pulls SDA low
   input  logic [6:0] dev_addr_i,
   input  logic [7:0] exp_ptr_i,
   output logic       sda_o,
   output logic [2:0] fault_o       // Wrong pointer, missing Sr, wrong burst length
);

   typedef enum logic [3:0] {
      SLV_IDLE, SLV_ADDR, SLV_ADDR_ACK, SLV_PTR, SLV_PTR_ACK,
      SLV_WAIT_RS, SLV_SEND, SLV_MACK, SLV_WAIT_STOP
   } slave_state_e;

   logic [7:0]   mem [256];
   slave_state_e state = SLV_IDLE;
   logic [7:0]   shreg = '0;
   logic [7:0]   tx_byte = '0;
   logic [7:0]   ptr = '0;
   int           bits = 0;
   int           sent = 0;
   logic         rw = 1'b0;
   logic         ptr_set = 1'b0;
   logic         master_ack = 1'b0;
   logic         pull = 1'b0;
   logic         scl_prev = 1'b1;
   logic         sda_prev = 1'b1;
   logic [2:0]   fault = '0;
   int           seed;
   wire          sda_line;

   assign sda_line = ~(sda_oe_i | pull);   // Open-drain wired AND
   assign sda_o    = sda_line;
   assign fault_o  = fault;

   initial
   begin
      seed = 9;
      for (int i = 0; i < 256; i++)
      begin
         mem[i] = 8'($random(seed));
      end
   end

   ////////////////////////////////////////
   // Bus events
   ////////////////////////////////////////

   always @(scl_i or sda_line)
   begin
      if (scl_i === 1'b1 && scl_prev === 1'b1 && sda_prev === 1'b1 && sda_line === 1'b0)
      begin   // START or repeated START
         if (state == SLV_SEND || state == SLV_MACK)
            fault[2] = 1'b1;
         state = SLV_ADDR;
         bits  = 0;
         pull  = 1'b0;
      end
      else if (scl_i === 1'b1 && scl_prev === 1'b1 && sda_prev === 1'b0 && sda_line === 1'b1)
      begin
         if (state == SLV_WAIT_RS)
            fault[1] = 1'b1;   // Pointer written but the read never started
         if (state == SLV_SEND || state == SLV_MACK)
            fault[2] = 1'b1;
         state   = SLV_IDLE;
         ptr_set = 1'b0;
         pull    = 1'b0;
      end
      else if (scl_i === 1'b1 && scl_prev === 1'b0)
      begin
         if (state == SLV_ADDR || state == SLV_PTR)
         begin
            shreg = {shreg[6:0], sda_line};
            bits++;
         end
         else if (state == SLV_MACK)
         begin
            master_ack = !sda_line;
            sent++;
            if (master_ack && sent == 6)
               fault[2] = 1'b1;
         end
      end
      else if (scl_i === 1'b0 && scl_prev === 1'b1)
      begin
         case (state)
            SLV_ADDR:
               if (bits == 8)
               begin
                  rw = shreg[0];
                  if (shreg[7:1] == dev_addr_i)
                  begin
                     pull  = 1'b1;
                     state = SLV_ADDR_ACK;
                     if (rw && !ptr_set)
                        fault[1] = 1'b1;
                  end
                  else
                     state = SLV_WAIT_STOP;   // Not our address, stay off the bus
               end
            SLV_ADDR_ACK:
               if (rw)
               begin
                  sent    = 0;
                  tx_byte = mem[ptr];
                  ptr     = ptr + 8'd1;   // Auto-increment as the device does
                  pull    = ~tx_byte[7];
                  bits    = 1;
                  state   = SLV_SEND;
               end
               else
               begin
                  pull  = 1'b0;
                  bits  = 0;
                  state = SLV_PTR;
               end
            SLV_PTR:
               if (bits == 8)
               begin
                  ptr     = shreg;
                  ptr_set = 1'b1;
                  pull    = 1'b1;
                  state   = SLV_PTR_ACK;
                  if (shreg != exp_ptr_i)
                     fault[0] = 1'b1;
               end
            SLV_PTR_ACK:
            begin
               pull  = 1'b0;
               state = SLV_WAIT_RS;
            end
            SLV_WAIT_RS: fault[1] = 1'b1;   // SCL fell again without Sr
            SLV_SEND:
               if (bits == 8)
               begin
                  pull  = 1'b0;   // Master owns the ACK bit
                  state = SLV_MACK;
               end
               else
               begin
                  pull = ~tx_byte[7 - bits];
                  bits++;
               end
            SLV_MACK:
               if (master_ack)
               begin
                  tx_byte = mem[ptr];
                  ptr     = ptr + 8'd1;
                  pull    = ~tx_byte[7];
                  bits    = 1;
                  state   = SLV_SEND;
               end
               else
               begin
                  pull  = 1'b0;
                  state = SLV_WAIT_STOP;
                  if (sent != 6)
                     fault[2] = 1'b1;
               end
            default: ;
         endcase
      end
      scl_prev = scl_i;
      sda_prev = sda_line;
   end

endmodule

//--- verif/tb_accel_reader.sv
`timescale 1ns/100ps

module tb_accel_reader;

   localparam int WB_LIMIT  = 20;
   localparam int IRQ_LIMIT = 5000;   // A burst takes about 700 clocks

   logic               clk;
   logic               rst_n;
   logic               wb_cyc;
   logic               wb_stb;
   logic               wb_we;
   accel_pkg::wb_adr_t wb_adr;
   accel_pkg::wb_dat_t wb_dat_w;
   accel_pkg::wb_dat_t wb_dat_r;
   logic               wb_ack;
   logic               scl;
   logic               sda;
   logic               sda_oe;
   logic               irq;
   logic [7:0]         expect_ptr;
   logic [2:0]         slave_fault;
   logic [47:0]        axes_exp;
   accel_pkg::wb_dat_t rd;

   accel_reader_top #(.SCL_HALF_CYCLES(4)) dut (
      .Clk_i (clk), .Reset_i (rst_n),
      .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_adr_i (wb_adr),
      .wb_dat_i (wb_dat_w), .wb_dat_o (wb_dat_r), .wb_ack_o (wb_ack),
      .scl_o (scl), .sda_i (sda), .sda_oe_o (sda_oe), .irq_o (irq)
   );

   adxl345_model model (
      .scl_i (scl), .sda_oe_i (sda_oe), .dev_addr_i (7'h53), .exp_ptr_i (expect_ptr),
      .sda_o (sda), .fault_o (slave_fault)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   task automatic stop_run(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic check(input string what, input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp)
      begin
         $display("Error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
         stop_run("A value read from the DUT did not match the expected value");
      end
   endtask

   // One classic cycle with ack and read data sampled on the falling edge
   task automatic transfer(input logic we, input accel_pkg::wb_adr_t adr,
                           input accel_pkg::wb_dat_t dat, output accel_pkg::wb_dat_t data);
      int waited;
      waited = 0;
      @(posedge clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_dat_w <= dat;
      do
      begin
         @(negedge clk);
         waited++;
         if (waited > WB_LIMIT)
            stop_run("Timeout: the register block never acknowledged a Wishbone transfer");
      end
      while (wb_ack !== 1'b1);
      data = wb_dat_r;
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic wb_write(input accel_pkg::wb_adr_t adr, input accel_pkg::wb_dat_t dat);
      accel_pkg::wb_dat_t unused;
      transfer(1'b1, adr, dat, unused);
   endtask

   task automatic wb_read(input accel_pkg::wb_adr_t adr, output accel_pkg::wb_dat_t data);
      transfer(1'b0, adr, '0, data);
   endtask

   task automatic wait_irq;
      int waited;
      waited = 0;
      while (irq !== 1'b1)
      begin
         @(negedge clk);
         waited++;
         if (waited > IRQ_LIMIT)
            stop_run("Timeout: irq_o did not rise after a start command");
      end
   endtask

   // Returns {Z, Y, X} with each axis as the high byte followed by the low byte
   function automatic logic [47:0] expected_axes(input logic [7:0] mem [256],
                                                 input logic [7:0] ptr);
      logic [7:0]  lo_adr;
      logic [7:0]  hi_adr;
      logic [47:0] axes;
      for (int i = 0; i < 3; i++)
      begin
         lo_adr           = ptr + 8'(2 * i);
         hi_adr           = lo_adr + 8'd1;   // Wraps like the device pointer
         axes[16*i +: 16] = {mem[hi_adr], mem[lo_adr]};
      end
      return axes;
   endfunction

   task automatic verify_axes(input logic [47:0] exp);
      accel_pkg::wb_dat_t value;
      wb_read(accel_pkg::REG_X, value);
      check("X", value, exp[15:0]);
      wb_read(accel_pkg::REG_Y, value);
      check("Y", value, exp[31:16]);
      wb_read(accel_pkg::REG_Z, value);
      check("Z", value, exp[47:32]);
   endtask

   always @(negedge clk)
   begin
      if (rst_n && slave_fault[0])
         stop_run("The slave model received a register pointer other than the one programmed");
      else if (rst_n && slave_fault[1])
         stop_run("The master read from the slave without a repeated START after the pointer");
      else if (rst_n && slave_fault[2])
         stop_run("The read burst did not end with a NACK after exactly six bytes");
   end

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial
   begin
      rst_n      = 1'b0;
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      wb_we      = 1'b0;
      wb_adr     = '0;
      wb_dat_w   = '0;
      expect_ptr = 8'h32;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;

      wb_read(accel_pkg::REG_DEV_ADDR, rd);
      check("DEV_ADDR after reset", rd, 16'h0053);
      wb_read(accel_pkg::REG_PTR, rd);
      check("PTR after reset", rd, 16'h0032);
      wb_read(accel_pkg::REG_STATUS, rd);
      check("STATUS after reset", rd, 16'h0000);
      verify_axes(48'd0);
      check("irq_o after reset", 16'(irq), 16'h0000);

      // Burst from DATAX0
      wb_write(accel_pkg::REG_CTRL, 16'h0001);
      wait_irq();
      axes_exp = expected_axes(model.mem, 8'h32);
      verify_axes(axes_exp);

      // Done is sticky until STATUS is read
      wb_read(accel_pkg::REG_STATUS, rd);
      check("STATUS after burst", rd, 16'h0002);
      check("irq_o after STATUS read", 16'(irq), 16'h0000);
      wb_read(accel_pkg::REG_STATUS, rd);
      check("STATUS second read", rd, 16'h0000);

      // A pointer near the top of the map makes the device address wrap
      expect_ptr = 8'hFC;
      wb_write(accel_pkg::REG_PTR, 16'h00FC);
      wb_read(accel_pkg::REG_PTR, rd);
      check("PTR after write", rd, 16'h00FC);
      wb_write(accel_pkg::REG_CTRL, 16'h0001);
      wait_irq();
      wb_read(accel_pkg::REG_STATUS, rd);
      check("STATUS after second burst", rd, 16'h0002);
      axes_exp = expected_axes(model.mem, 8'hFC);
      verify_axes(axes_exp);

      // Address the model does not answer
      wb_write(accel_pkg::REG_DEV_ADDR, 16'h001D);
      wb_write(accel_pkg::REG_CTRL, 16'h0001);
      wait_irq();
      wb_read(accel_pkg::REG_STATUS, rd);
      check("STATUS after NACK", rd, 16'h0006);
      verify_axes(axes_exp);   // Unchanged since the last good burst

      $display(">>> PASS");
      $finish;
   end

endmodule
